//--- verilog/lce_pkg.sv
// ************************************************
// shared definitions of the lce command engine
// cache and address sizes, message and memory op enums
// packed structs for command, response and memory packets
// ************************************************

package lce_pkg;

  // cache geometry and system sizes
  localparam int LCE_SETS = 16;
  localparam int LCE_ASSOC = 4;
  localparam int NUM_CCE = 2;
  localparam int PADDR_WIDTH = 22;
  localparam int BLOCK_WIDTH = 64;
  localparam int ID_WIDTH = 2;
  localparam int BLOCK_OFFSET_WIDTH = 3;

  // derived field widths
  localparam int INDEX_WIDTH = $clog2(LCE_SETS);
  localparam int TAG_WIDTH = PADDR_WIDTH - INDEX_WIDTH - BLOCK_OFFSET_WIDTH;
  localparam int WAY_WIDTH = $clog2(LCE_ASSOC);

  // shared by the set sweep and the sync count
  localparam int CNT_WIDTH = (INDEX_WIDTH > ID_WIDTH) ? (INDEX_WIDTH + 1) : (ID_WIDTH + 1);

  // commands from the directory
  typedef enum logic [2:0] {
    e_cmd_sync,
    e_cmd_set_clear,
    e_cmd_set_tag,
    e_cmd_invalidate_tag,
    e_cmd_writeback
  } lce_cmd_type_e;

  // responses back to the directory
  typedef enum logic [1:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_wb,
    e_resp_null_wb
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_coh_i,
    e_coh_s,
    e_coh_e,
    e_coh_m
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_tag,
    e_tag_invalidate
  } tag_op_e;

  typedef enum logic [1:0] {
    e_stat_set_clear,
    e_stat_read,
    e_stat_clear_dirty
  } stat_op_e;

  // reset sweep, then syncs, then full coherence
  typedef enum logic [1:0] {
    e_mode_reset,
    e_mode_uncached_only,
    e_mode_ready
  } lce_mode_e;

  typedef struct packed {
    lce_cmd_type_e msg_type;
    logic [ID_WIDTH-1:0] src_id;
    logic [WAY_WIDTH-1:0] way_id;
    logic [PADDR_WIDTH-1:0] addr;
    coh_state_e state;
  } lce_cmd_s;

  typedef struct packed {
    lce_resp_type_e msg_type;
    logic [ID_WIDTH-1:0] src_id;
    logic [ID_WIDTH-1:0] dst_id;
    logic [PADDR_WIDTH-1:0] addr;
    logic [BLOCK_WIDTH-1:0] data;
  } lce_resp_s;

  typedef struct packed {
    tag_op_e opcode;
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0] way_id;
    coh_state_e state;
    logic [TAG_WIDTH-1:0] tag;
  } tag_mem_pkt_s;

  typedef struct packed {
    stat_op_e opcode;
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0] way_id;
  } stat_mem_pkt_s;

  // data memory is read only here
  typedef struct packed {
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0] way_id;
  } data_mem_pkt_s;

endpackage

//--- verilog/lce_init_sync.sv
// ************************************************
// initialization and sync sequencer
// clears tag and status memories set by set after reset,
// acks one sync per directory, then enters ready mode
// ************************************************

module lce_init_sync
  import lce_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [ID_WIDTH-1:0] lce_id_i,

  input  lce_cmd_s            lce_cmd_i,
  input  logic                lce_cmd_v_i,
  output logic                lce_cmd_yumi_o,

  output lce_resp_s           lce_resp_o,
  output logic                lce_resp_v_o,
  input  logic                lce_resp_yumi_i,

  output tag_mem_pkt_s        tag_mem_pkt_o,
  output logic                tag_mem_pkt_v_o,
  input  logic                tag_mem_pkt_yumi_i,

  output stat_mem_pkt_s       stat_mem_pkt_o,
  output logic                stat_mem_pkt_v_o,
  input  logic                stat_mem_pkt_yumi_i,

  output lce_mode_e           lce_mode_o,
  output logic                lce_ready_o
);

  lce_mode_e mode_r, mode_n;
  logic [CNT_WIDTH-1:0] cnt_r, cnt_n;

  assign lce_mode_o = mode_r;
  assign lce_ready_o = (mode_r == e_mode_ready);

  always_comb begin
    mode_n = mode_r;
    cnt_n = cnt_r;

    lce_cmd_yumi_o = 1'b0;
    lce_resp_o = '0;
    lce_resp_v_o = 1'b0;
    tag_mem_pkt_o = '0;
    tag_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_o = '0;
    stat_mem_pkt_v_o = 1'b0;

    case (mode_r)
      e_mode_reset: begin
        // one set per accepted pair of packets
        tag_mem_pkt_o.opcode = e_tag_set_clear;
        tag_mem_pkt_o.index = cnt_r[INDEX_WIDTH-1:0];
        tag_mem_pkt_o.state = e_coh_i;
        tag_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_set_clear;
        stat_mem_pkt_o.index = cnt_r[INDEX_WIDTH-1:0];
        stat_mem_pkt_v_o = 1'b1;
        if (tag_mem_pkt_yumi_i && stat_mem_pkt_yumi_i) begin
          if (cnt_r == CNT_WIDTH'(LCE_SETS - 1)) begin
            mode_n = e_mode_uncached_only;
            cnt_n = '0;
          end else begin
            cnt_n = cnt_r + 1'b1;
          end
        end
      end

      e_mode_uncached_only: begin
        if (lce_cmd_v_i && (lce_cmd_i.msg_type == e_cmd_sync)) begin
          lce_resp_o.msg_type = e_resp_sync_ack;
          lce_resp_o.src_id = lce_id_i;
          lce_resp_o.dst_id = lce_cmd_i.src_id;
          lce_resp_v_o = 1'b1;
          lce_cmd_yumi_o = lce_resp_yumi_i;
          if (lce_resp_yumi_i) begin
            // last directory synced
            if (cnt_r == CNT_WIDTH'(NUM_CCE - 1)) begin
              mode_n = e_mode_ready;
              cnt_n = '0;
            end else begin
              cnt_n = cnt_r + 1'b1;
            end
          end
        end
      end

      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r <= e_mode_reset;
      cnt_r <= '0;
    end else begin
      mode_r <= mode_n;
      cnt_r <= cnt_n;
    end
  end

endmodule

//--- verilog/lce_coherence_fsm.sv
// ************************************************
// coherence command engine
// set_clear, set_tag, invalidate_tag and writeback handling
// sequences tag, status and data memory packets and responses
// ************************************************

module lce_coherence_fsm
  import lce_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [ID_WIDTH-1:0]    lce_id_i,
  input  lce_mode_e              lce_mode_i,

  input  lce_cmd_s               lce_cmd_i,
  input  logic                   lce_cmd_v_i,
  output logic                   lce_cmd_yumi_o,

  output lce_resp_s              lce_resp_o,
  output logic                   lce_resp_v_o,
  input  logic                   lce_resp_yumi_i,

  output tag_mem_pkt_s           tag_mem_pkt_o,
  output logic                   tag_mem_pkt_v_o,
  input  logic                   tag_mem_pkt_yumi_i,

  output stat_mem_pkt_s          stat_mem_pkt_o,
  output logic                   stat_mem_pkt_v_o,
  input  logic                   stat_mem_pkt_yumi_i,
  input  logic [LCE_ASSOC-1:0]   dirty_i,

  output data_mem_pkt_s          data_mem_pkt_o,
  output logic                   data_mem_pkt_v_o,
  input  logic                   data_mem_pkt_yumi_i,
  input  logic [BLOCK_WIDTH-1:0] data_mem_data_i
);

  typedef enum logic [1:0] {
    e_st_idle,
    e_st_wb_check,
    e_st_wb_dirty,
    e_st_wb_clean
  } coh_fsm_state_e;

  coh_fsm_state_e state_r, state_n;

  // progress of a multi step command
  logic inv_done_r, inv_done_n;
  logic rd_done_r, rd_done_n;
  logic clr_done_r, clr_done_n;

  // block read for a dirty writeback
  logic buf_full_r, buf_full_n;
  logic [BLOCK_WIDTH-1:0] data_buf_r, data_buf_n;

  logic [INDEX_WIDTH-1:0] cmd_index;
  logic [TAG_WIDTH-1:0] cmd_tag;
  logic cmd_active;
  logic ready_mode;

  assign cmd_index = lce_cmd_i.addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
  assign cmd_tag = lce_cmd_i.addr[BLOCK_OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
  assign ready_mode = (lce_mode_i == e_mode_ready);
  // reset mode belongs to the sequencer
  assign cmd_active = lce_cmd_v_i & (lce_mode_i != e_mode_reset);

  // response addressed back to the directory that sent the command
  function automatic lce_resp_s build_resp(input lce_resp_type_e msg_type,
                                           input logic [BLOCK_WIDTH-1:0] data,
                                           input logic [ID_WIDTH-1:0] own_id,
                                           input lce_cmd_s cmd);
    lce_resp_s resp;
    resp.msg_type = msg_type;
    resp.src_id = own_id;
    resp.dst_id = cmd.src_id;
    resp.addr = cmd.addr;
    resp.data = data;
    return resp;
  endfunction

  always_comb begin
    state_n = state_r;
    inv_done_n = inv_done_r;
    rd_done_n = rd_done_r;
    clr_done_n = clr_done_r;
    buf_full_n = buf_full_r;
    data_buf_n = data_buf_r;

    lce_cmd_yumi_o = 1'b0;
    lce_resp_o = '0;
    lce_resp_v_o = 1'b0;
    tag_mem_pkt_o = '0;
    tag_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_o = '0;
    stat_mem_pkt_v_o = 1'b0;
    data_mem_pkt_o = '0;
    data_mem_pkt_v_o = 1'b0;

    case (state_r)
      e_st_idle: begin
        if (cmd_active) begin
          case (lce_cmd_i.msg_type)
            e_cmd_set_clear: begin
              tag_mem_pkt_o.opcode = e_tag_set_clear;
              tag_mem_pkt_o.index = cmd_index;
              tag_mem_pkt_o.state = e_coh_i;
              tag_mem_pkt_v_o = 1'b1;
              stat_mem_pkt_o.opcode = e_stat_set_clear;
              stat_mem_pkt_o.index = cmd_index;
              stat_mem_pkt_v_o = 1'b1;
              lce_cmd_yumi_o = tag_mem_pkt_yumi_i & stat_mem_pkt_yumi_i;
            end

            e_cmd_set_tag: begin
              if (ready_mode) begin
                tag_mem_pkt_o.opcode = e_tag_set_tag;
                tag_mem_pkt_o.index = cmd_index;
                tag_mem_pkt_o.way_id = lce_cmd_i.way_id;
                tag_mem_pkt_o.state = lce_cmd_i.state;
                tag_mem_pkt_o.tag = cmd_tag;
                tag_mem_pkt_v_o = 1'b1;
                lce_cmd_yumi_o = tag_mem_pkt_yumi_i;
              end
            end

            e_cmd_invalidate_tag: begin
              if (ready_mode) begin
                // tag first, ack offered from the tag yumi on
                if (!inv_done_r) begin
                  tag_mem_pkt_o.opcode = e_tag_invalidate;
                  tag_mem_pkt_o.index = cmd_index;
                  tag_mem_pkt_o.way_id = lce_cmd_i.way_id;
                  tag_mem_pkt_v_o = 1'b1;
                end
                lce_resp_v_o = inv_done_r | tag_mem_pkt_yumi_i;
                if (lce_resp_v_o) begin
                  lce_resp_o = build_resp(e_resp_inv_ack, '0, lce_id_i, lce_cmd_i);
                end
                lce_cmd_yumi_o = lce_resp_yumi_i;
                inv_done_n = ~lce_resp_yumi_i & (inv_done_r | tag_mem_pkt_yumi_i);
              end
            end

            e_cmd_writeback: begin
              if (ready_mode) begin
                stat_mem_pkt_o.opcode = e_stat_read;
                stat_mem_pkt_o.index = cmd_index;
                stat_mem_pkt_o.way_id = lce_cmd_i.way_id;
                stat_mem_pkt_v_o = 1'b1;
                if (stat_mem_pkt_yumi_i) begin
                  state_n = e_st_wb_check;
                end
              end
            end

            default: begin
            end
          endcase
        end
      end

      // dirty bits arrive one cycle after the status read
      e_st_wb_check: begin
        state_n = dirty_i[lce_cmd_i.way_id] ? e_st_wb_dirty : e_st_wb_clean;
      end

      e_st_wb_dirty: begin
        if (!rd_done_r) begin
          data_mem_pkt_o.index = cmd_index;
          data_mem_pkt_o.way_id = lce_cmd_i.way_id;
          data_mem_pkt_v_o = 1'b1;
        end
        rd_done_n = rd_done_r | data_mem_pkt_yumi_i;

        // read data is only valid in the cycle after the yumi
        if (rd_done_r && !buf_full_r) begin
          data_buf_n = data_mem_data_i;
          buf_full_n = 1'b1;
        end

        if (rd_done_r && !clr_done_r) begin
          stat_mem_pkt_o.opcode = e_stat_clear_dirty;
          stat_mem_pkt_o.index = cmd_index;
          stat_mem_pkt_o.way_id = lce_cmd_i.way_id;
          stat_mem_pkt_v_o = 1'b1;
        end
        clr_done_n = clr_done_r | stat_mem_pkt_yumi_i;

        lce_resp_v_o = buf_full_r & clr_done_r;
        if (lce_resp_v_o) begin
          lce_resp_o = build_resp(e_resp_wb, data_buf_r, lce_id_i, lce_cmd_i);
        end
        lce_cmd_yumi_o = lce_resp_yumi_i;
        if (lce_resp_yumi_i) begin
          rd_done_n = 1'b0;
          clr_done_n = 1'b0;
          buf_full_n = 1'b0;
          state_n = e_st_idle;
        end
      end

      e_st_wb_clean: begin
        lce_resp_v_o = 1'b1;
        lce_resp_o = build_resp(e_resp_null_wb, '0, lce_id_i, lce_cmd_i);
        lce_cmd_yumi_o = lce_resp_yumi_i;
        if (lce_resp_yumi_i) begin
          state_n = e_st_idle;
        end
      end

      default: begin
        state_n = e_st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_st_idle;
      inv_done_r <= 1'b0;
      rd_done_r <= 1'b0;
      clr_done_r <= 1'b0;
      buf_full_r <= 1'b0;
    end else begin
      state_r <= state_n;
      inv_done_r <= inv_done_n;
      rd_done_r <= rd_done_n;
      clr_done_r <= clr_done_n;
      buf_full_r <= buf_full_n;
    end
  end

  always_ff @(posedge clk_i) begin
    data_buf_r <= data_buf_n;
  end

endmodule

//--- verilog/lce_cmd_top.sv
// ************************************************
// lce command side top level
// sequencer and coherence engine run side by side,
// their idle-zero outputs are merged onto shared ports
// ************************************************

module lce_cmd_top
  import lce_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [ID_WIDTH-1:0]    lce_id_i,
  output logic                   lce_ready_o,

  input  lce_cmd_s               lce_cmd_i,
  input  logic                   lce_cmd_v_i,
  output logic                   lce_cmd_yumi_o,

  output lce_resp_s              lce_resp_o,
  output logic                   lce_resp_v_o,
  input  logic                   lce_resp_yumi_i,

  output tag_mem_pkt_s           tag_mem_pkt_o,
  output logic                   tag_mem_pkt_v_o,
  input  logic                   tag_mem_pkt_yumi_i,

  output stat_mem_pkt_s          stat_mem_pkt_o,
  output logic                   stat_mem_pkt_v_o,
  input  logic                   stat_mem_pkt_yumi_i,
  input  logic [LCE_ASSOC-1:0]   dirty_i,

  output data_mem_pkt_s          data_mem_pkt_o,
  output logic                   data_mem_pkt_v_o,
  input  logic                   data_mem_pkt_yumi_i,
  input  logic [BLOCK_WIDTH-1:0] data_mem_data_i
);

  lce_mode_e lce_mode;

  // sequencer side
  logic init_cmd_yumi;
  lce_resp_s init_resp;
  logic init_resp_v;
  tag_mem_pkt_s init_tag_pkt;
  logic init_tag_v;
  stat_mem_pkt_s init_stat_pkt;
  logic init_stat_v;

  // coherence engine side
  logic coh_cmd_yumi;
  lce_resp_s coh_resp;
  logic coh_resp_v;
  tag_mem_pkt_s coh_tag_pkt;
  logic coh_tag_v;
  stat_mem_pkt_s coh_stat_pkt;
  logic coh_stat_v;

  lce_init_sync i_init_sync (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .lce_id_i            (lce_id_i),
    .lce_cmd_i           (lce_cmd_i),
    .lce_cmd_v_i         (lce_cmd_v_i),
    .lce_cmd_yumi_o      (init_cmd_yumi),
    .lce_resp_o          (init_resp),
    .lce_resp_v_o        (init_resp_v),
    .lce_resp_yumi_i     (lce_resp_yumi_i),
    .tag_mem_pkt_o       (init_tag_pkt),
    .tag_mem_pkt_v_o     (init_tag_v),
    .tag_mem_pkt_yumi_i  (tag_mem_pkt_yumi_i),
    .stat_mem_pkt_o      (init_stat_pkt),
    .stat_mem_pkt_v_o    (init_stat_v),
    .stat_mem_pkt_yumi_i (stat_mem_pkt_yumi_i),
    .lce_mode_o          (lce_mode),
    .lce_ready_o         (lce_ready_o)
  );

  lce_coherence_fsm i_coh_fsm (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .lce_id_i            (lce_id_i),
    .lce_mode_i          (lce_mode),
    .lce_cmd_i           (lce_cmd_i),
    .lce_cmd_v_i         (lce_cmd_v_i),
    .lce_cmd_yumi_o      (coh_cmd_yumi),
    .lce_resp_o          (coh_resp),
    .lce_resp_v_o        (coh_resp_v),
    .lce_resp_yumi_i     (lce_resp_yumi_i),
    .tag_mem_pkt_o       (coh_tag_pkt),
    .tag_mem_pkt_v_o     (coh_tag_v),
    .tag_mem_pkt_yumi_i  (tag_mem_pkt_yumi_i),
    .stat_mem_pkt_o      (coh_stat_pkt),
    .stat_mem_pkt_v_o    (coh_stat_v),
    .stat_mem_pkt_yumi_i (stat_mem_pkt_yumi_i),
    .dirty_i             (dirty_i),
    .data_mem_pkt_o      (data_mem_pkt_o),
    .data_mem_pkt_v_o    (data_mem_pkt_v_o),
    .data_mem_pkt_yumi_i (data_mem_pkt_yumi_i),
    .data_mem_data_i     (data_mem_data_i)
  );

  // never both active on one channel, so OR is a safe merge
  assign lce_cmd_yumi_o = init_cmd_yumi | coh_cmd_yumi;
  assign lce_resp_o = init_resp | coh_resp;
  assign lce_resp_v_o = init_resp_v | coh_resp_v;
  assign tag_mem_pkt_o = init_tag_pkt | coh_tag_pkt;
  assign tag_mem_pkt_v_o = init_tag_v | coh_tag_v;
  assign stat_mem_pkt_o = init_stat_pkt | coh_stat_pkt;
  assign stat_mem_pkt_v_o = init_stat_v | coh_stat_v;

endmodule

//--- dv/lce_cmd_assert.sv
// **************************************************
// handshake assertions bound to lce_cmd_top
// valid/packet hold, yumi only with valid, ready sticky
// **************************************************

module lce_cmd_assert
  import lce_pkg::*;
(
  input logic          clk_i,
  input logic          reset_i,
  input logic          lce_ready_i,
  input logic          cmd_v_i,
  input logic          cmd_yumi_i,
  input lce_resp_s     resp_i,
  input logic          resp_v_i,
  input logic          resp_yumi_i,
  input tag_mem_pkt_s  tag_i,
  input logic          tag_v_i,
  input logic          tag_yumi_i,
  input stat_mem_pkt_s stat_i,
  input logic          stat_v_i,
  input logic          stat_yumi_i,
  input data_mem_pkt_s data_i,
  input logic          data_v_i,
  input logic          data_yumi_i
);

  int fail_cnt = 0;

  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i && $stable(resp_i))
    else begin fail_cnt++; $error("response dropped before yumi"); end
  a_tag_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_v_i && !tag_yumi_i |=> tag_v_i && $stable(tag_i))
    else begin fail_cnt++; $error("tag packet dropped before yumi"); end
  a_stat_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    stat_v_i && !stat_yumi_i |=> stat_v_i && $stable(stat_i))
    else begin fail_cnt++; $error("status packet dropped before yumi"); end
  a_data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i && !data_yumi_i |=> data_v_i && $stable(data_i))
    else begin fail_cnt++; $error("data packet dropped before yumi"); end
  // the command yumi is the only one the DUT produces
  a_yumi_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_i |-> cmd_v_i)
    else begin fail_cnt++; $error("yumi without valid"); end
  a_ready_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_ready_i |=> lce_ready_i)
    else begin fail_cnt++; $error("lce_ready_o fell"); end

endmodule

bind lce_cmd_top lce_cmd_assert i_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .lce_ready_i (lce_ready_o),
  .cmd_v_i     (lce_cmd_v_i),
  .cmd_yumi_i  (lce_cmd_yumi_o),
  .resp_i      (lce_resp_o),
  .resp_v_i    (lce_resp_v_o),
  .resp_yumi_i (lce_resp_yumi_i),
  .tag_i       (tag_mem_pkt_o),
  .tag_v_i     (tag_mem_pkt_v_o),
  .tag_yumi_i  (tag_mem_pkt_yumi_i),
  .stat_i      (stat_mem_pkt_o),
  .stat_v_i    (stat_mem_pkt_v_o),
  .stat_yumi_i (stat_mem_pkt_yumi_i),
  .data_i      (data_mem_pkt_o),
  .data_v_i    (data_mem_pkt_v_o),
  .data_yumi_i (data_mem_pkt_yumi_i)
);

//--- dv/lce_cmd_tests.svh
// **************************************************
// directed tests of the lce command engine
// reset sweep, sync, set_clear, set_tag,
// invalidate_tag and writeback
// **************************************************

`ifndef LCE_CMD_TESTS_SVH
`define LCE_CMD_TESTS_SVH

function automatic lce_cmd_s make_cmd(input lce_cmd_type_e t, input logic [ID_WIDTH-1:0] src,
                                      input int way, input logic [PADDR_WIDTH-1:0] addr,
                                      input coh_state_e st);
  lce_cmd_s c;
  c.msg_type = t;
  c.src_id = src;
  c.way_id = WAY_WIDTH'(way);
  c.addr = addr;
  c.state = st;
  return c;
endfunction

function automatic lce_resp_s make_resp(input lce_resp_type_e t, input logic [ID_WIDTH-1:0] dst,
                                        input logic [PADDR_WIDTH-1:0] addr,
                                        input logic [BLOCK_WIDTH-1:0] data);
  lce_resp_s r;
  r.msg_type = t;
  r.src_id = OWN_ID;
  r.dst_id = dst;
  r.addr = addr;
  r.data = data;
  return r;
endfunction

function automatic int index_of(input logic [PADDR_WIDTH-1:0] addr);
  return int'(addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH]);
endfunction

task automatic clear_queues();
  tag_q.delete();
  stat_q.delete();
  data_q.delete();
  resp_q.delete();
endtask

// hold the command until the DUT takes it
task automatic issue_cmd(input lce_cmd_s cmd);
  @(negedge clk_i);
  lce_cmd_i = cmd;
  lce_cmd_v_i = 1'b1;
  do @(posedge clk_i); while (!lce_cmd_yumi_o);
  @(negedge clk_i);
  lce_cmd_v_i = 1'b0;
  lce_cmd_i = '0;
endtask

task automatic expect_tag(input tag_mem_pkt_s exp);
  checks++;
  if (tag_q.size() == 0) begin
    $display("missing tag packet, expected %h", exp);
    errors++;
  end else if (tag_q[0] !== exp) begin
    $display("error: tag_mem_pkt_o got %h expected %h", tag_q[0], exp);
    errors++;
    void'(tag_q.pop_front());
  end else begin
    void'(tag_q.pop_front());
  end
endtask

task automatic expect_stat(input stat_mem_pkt_s exp);
  checks++;
  if (stat_q.size() == 0) begin
    $display("missing status packet, expected %h", exp);
    errors++;
  end else if (stat_q[0] !== exp) begin
    $display("error: stat_mem_pkt_o got %h expected %h", stat_q[0], exp);
    errors++;
    void'(stat_q.pop_front());
  end else begin
    void'(stat_q.pop_front());
  end
endtask

task automatic expect_resp(input lce_resp_s exp);
  checks++;
  if (resp_q.size() == 0) begin
    $display("missing response, expected %h", exp);
    errors++;
  end else if (resp_q[0] !== exp) begin
    $display("error: lce_resp_o got %h expected %h", resp_q[0], exp);
    errors++;
    void'(resp_q.pop_front());
  end else begin
    void'(resp_q.pop_front());
  end
endtask

// nothing extra may be left on any channel
task automatic expect_drained(input string name);
  checks++;
  if (tag_q.size() + stat_q.size() + data_q.size() + resp_q.size() != 0) begin
    $display("%s left extra packets: tag %0d stat %0d data %0d resp %0d", name,
             tag_q.size(), stat_q.size(), data_q.size(), resp_q.size());
    errors++;
  end
endtask

task automatic report_test(input string name, input int start_errors);
  tests_run++;
  if (errors == start_errors) begin
    $display("%s: ok", name);
  end else begin
    $display("%s: %0d errors", name, errors - start_errors);
  end
endtask

task automatic check_reset_sweep();
  int e0;
  tag_mem_pkt_s t;
  stat_mem_pkt_s s;
  e0 = errors;
  while (stat_q.size() < LCE_SETS) begin
    @(negedge clk_i);
    checks++;
    if (lce_ready_o !== 1'b0) begin
      $display("error: lce_ready_o got %h expected 0", lce_ready_o);
      errors++;
    end
  end
  repeat (3) @(negedge clk_i);
  for (int i = 0; i < LCE_SETS; i++) begin
    t = '0;
    t.opcode = e_tag_set_clear;
    t.index = INDEX_WIDTH'(i);
    t.state = e_coh_i;
    s = '0;
    s.opcode = e_stat_set_clear;
    s.index = INDEX_WIDTH'(i);
    expect_tag(t);
    expect_stat(s);
  end
  expect_drained("reset sweep");
  report_test("reset sweep", e0);
endtask

task automatic check_sync();
  int e0;
  e0 = errors;
  clear_queues();
  issue_cmd(make_cmd(e_cmd_sync, 2'd0, 0, '0, e_coh_i));
  expect_resp(make_resp(e_resp_sync_ack, 2'd0, '0, '0));
  checks++;
  if (lce_ready_o !== 1'b0) begin
    $display("error: lce_ready_o got %h expected 0", lce_ready_o);
    errors++;
  end
  issue_cmd(make_cmd(e_cmd_sync, 2'd1, 0, '0, e_coh_i));
  expect_resp(make_resp(e_resp_sync_ack, 2'd1, '0, '0));
  checks++;
  if (lce_ready_o !== 1'b1) begin
    $display("error: lce_ready_o got %h expected 1", lce_ready_o);
    errors++;
  end
  expect_drained("sync");
  report_test("sync", e0);
endtask

task automatic check_set_clear(input logic [PADDR_WIDTH-1:0] addr, input logic [1:0] src);
  int e0;
  tag_mem_pkt_s t;
  stat_mem_pkt_s s;
  e0 = errors;
  clear_queues();
  issue_cmd(make_cmd(e_cmd_set_clear, src, 0, addr, e_coh_i));
  t = '0;
  t.opcode = e_tag_set_clear;
  t.index = INDEX_WIDTH'(index_of(addr));
  t.state = e_coh_i;
  s = '0;
  s.opcode = e_stat_set_clear;
  s.index = INDEX_WIDTH'(index_of(addr));
  expect_tag(t);
  expect_stat(s);
  expect_drained("set_clear");
  report_test("set_clear", e0);
endtask

task automatic check_set_tag(input logic [PADDR_WIDTH-1:0] addr, input int way,
                             input coh_state_e st);
  int e0;
  tag_mem_pkt_s t;
  e0 = errors;
  clear_queues();
  issue_cmd(make_cmd(e_cmd_set_tag, 2'd1, way, addr, st));
  t.opcode = e_tag_set_tag;
  t.index = INDEX_WIDTH'(index_of(addr));
  t.way_id = WAY_WIDTH'(way);
  t.state = st;
  t.tag = addr[PADDR_WIDTH-1 -: TAG_WIDTH];
  expect_tag(t);
  expect_drained("set_tag");
  report_test("set_tag", e0);
endtask

task automatic check_invalidate(input logic [PADDR_WIDTH-1:0] addr, input int way);
  int e0;
  tag_mem_pkt_s t;
  e0 = errors;
  clear_queues();
  issue_cmd(make_cmd(e_cmd_invalidate_tag, 2'd0, way, addr, e_coh_s));
  t = '0;
  t.opcode = e_tag_invalidate;
  t.index = INDEX_WIDTH'(index_of(addr));
  t.way_id = WAY_WIDTH'(way);
  expect_tag(t);
  expect_resp(make_resp(e_resp_inv_ack, 2'd0, addr, '0));
  expect_drained("invalidate_tag");
  report_test("invalidate_tag", e0);
endtask

task automatic check_writeback(input logic [PADDR_WIDTH-1:0] addr, input int way,
                               input logic dirty);
  int e0;
  int idx;
  stat_mem_pkt_s s;
  data_mem_pkt_s d;
  data_mem_pkt_s got;
  e0 = errors;
  idx = index_of(addr);
  clear_queues();
  dirty_mem[idx][way] = dirty;
  issue_cmd(make_cmd(e_cmd_writeback, 2'd1, way, addr, e_coh_m));
  s.opcode = e_stat_read;
  s.index = INDEX_WIDTH'(idx);
  s.way_id = WAY_WIDTH'(way);
  expect_stat(s);
  if (dirty) begin
    d.index = INDEX_WIDTH'(idx);
    d.way_id = WAY_WIDTH'(way);
    checks++;
    if (data_q.size() == 0) begin
      $display("missing data read on a dirty writeback");
      errors++;
    end else begin
      got = data_q.pop_front();
      if (got !== d) begin
        $display("error: data_mem_pkt_o got %h expected %h", got, d);
        errors++;
      end
    end
    s.opcode = e_stat_clear_dirty;
    expect_stat(s);
    expect_resp(make_resp(e_resp_wb, 2'd1, addr, block_pattern(idx, way)));
  end else begin
    expect_resp(make_resp(e_resp_null_wb, 2'd1, addr, '0));
  end
  expect_drained(dirty ? "writeback dirty" : "writeback clean");
  report_test(dirty ? "writeback dirty" : "writeback clean", e0);
endtask

task automatic run_coherence_tests();
  check_set_clear(22'h2b3f18, 2'd0);
  check_set_tag(22'h3c4d70, 2, e_coh_e);
  check_set_tag(22'h0123a8, 1, e_coh_m);
  check_invalidate(22'h155540, 3);
  check_writeback(22'h1f0e28, 1, 1'b1);
  check_writeback(22'h0a0b78, 2, 1'b0);
endtask

`endif

//--- dv/tb_lce_cmd.sv
// **************************************************
// testbench top for the lce command engine
// clock, reset, tag/status/data memory models,
// lfsr yumi stalls, cycle timeout and run summary
// **************************************************

module tb_lce_cmd
  import lce_pkg::*;
();

  // about 600 cycles of tests, with stall headroom
  localparam int MAX_CYCLES = 4000;
  localparam logic [ID_WIDTH-1:0] OWN_ID = 2'd2;

  logic clk_i;
  logic reset_i;
  logic lce_ready_o;
  lce_cmd_s lce_cmd_i;
  logic lce_cmd_v_i;
  logic lce_cmd_yumi_o;
  lce_resp_s lce_resp_o;
  logic lce_resp_v_o;
  logic lce_resp_yumi_i;
  tag_mem_pkt_s tag_mem_pkt_o;
  logic tag_mem_pkt_v_o;
  logic tag_mem_pkt_yumi_i;
  stat_mem_pkt_s stat_mem_pkt_o;
  logic stat_mem_pkt_v_o;
  logic stat_mem_pkt_yumi_i;
  logic [LCE_ASSOC-1:0] dirty_i;
  data_mem_pkt_s data_mem_pkt_o;
  logic data_mem_pkt_v_o;
  logic data_mem_pkt_yumi_i;
  logic [BLOCK_WIDTH-1:0] data_mem_data_i;

  // per channel grants, gated by valid below
  logic resp_g, tag_g, stat_g, data_g;
  logic stall_on;
  logic [31:0] lfsr_r;
  int cycle_cnt;
  int errors;
  int checks;
  int tests_run;

  // memory models
  logic dirty_mem [LCE_SETS][LCE_ASSOC];
  logic [BLOCK_WIDTH-1:0] block_mem [LCE_SETS][LCE_ASSOC];
  logic dirty_pend, data_pend;
  logic [LCE_ASSOC-1:0] dirty_next;
  logic [BLOCK_WIDTH-1:0] data_next;

  // transfers seen on each channel
  tag_mem_pkt_s tag_q[$];
  stat_mem_pkt_s stat_q[$];
  data_mem_pkt_s data_q[$];
  lce_resp_s resp_q[$];

  lce_cmd_top i_dut (.*, .lce_id_i(OWN_ID));

  assign lce_resp_yumi_i = lce_resp_v_o & resp_g;
  assign data_mem_pkt_yumi_i = data_mem_pkt_v_o & data_g;
  // a set_clear pair is taken by both memories together
  assign tag_mem_pkt_yumi_i = tag_mem_pkt_v_o & (stat_mem_pkt_v_o ? (tag_g & stat_g) : tag_g);
  assign stat_mem_pkt_yumi_i = stat_mem_pkt_v_o & (tag_mem_pkt_v_o ? (tag_g & stat_g) : stat_g);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // fill pattern built from set and way
  function automatic logic [BLOCK_WIDTH-1:0] block_pattern(input int s, input int w);
    logic [31:0] hi;
    hi = {16'hb10c, 8'(s), 8'(w)};
    return {hi, ~hi ^ {8'(w), 8'(s), 16'h5a5a}};
  endfunction

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (tag_mem_pkt_yumi_i) begin
        tag_q.push_back(tag_mem_pkt_o);
      end
      if (stat_mem_pkt_yumi_i) begin
        stat_q.push_back(stat_mem_pkt_o);
        case (stat_mem_pkt_o.opcode)
          e_stat_read: begin
            for (int w = 0; w < LCE_ASSOC; w++) begin
              dirty_next[w] = dirty_mem[stat_mem_pkt_o.index][w];
            end
            dirty_pend = 1'b1;
          end
          e_stat_clear_dirty: dirty_mem[stat_mem_pkt_o.index][stat_mem_pkt_o.way_id] = 1'b0;
          default: begin
            for (int w = 0; w < LCE_ASSOC; w++) begin
              dirty_mem[stat_mem_pkt_o.index][w] = 1'b0;
            end
          end
        endcase
      end
      if (data_mem_pkt_yumi_i) begin
        data_q.push_back(data_mem_pkt_o);
        data_next = block_mem[data_mem_pkt_o.index][data_mem_pkt_o.way_id];
        data_pend = 1'b1;
      end
      if (lce_resp_yumi_i) begin
        resp_q.push_back(lce_resp_o);
      end
    end
  end

  // grants and read returns change on the falling edge
  always @(negedge clk_i) begin
    if (stall_on) begin
      lfsr_r = lfsr_next(lfsr_r);
      resp_g = lfsr_r[0];
      lfsr_r = lfsr_next(lfsr_r);
      tag_g = lfsr_r[0];
      lfsr_r = lfsr_next(lfsr_r);
      stat_g = lfsr_r[0];
      lfsr_r = lfsr_next(lfsr_r);
      data_g = lfsr_r[0];
    end else begin
      resp_g = 1'b1;
      tag_g = 1'b1;
      stat_g = 1'b1;
      data_g = 1'b1;
    end
    if (dirty_pend) begin
      dirty_i = dirty_next;
      dirty_pend = 1'b0;
    end
    if (data_pend) begin
      data_mem_data_i = data_next;
      data_pend = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  `include "lce_cmd_tests.svh"

  initial begin
    int total;
    clk_i = 1'b0;
    reset_i = 1'b1;
    lce_cmd_i = '0;
    lce_cmd_v_i = 1'b0;
    dirty_i = '0;
    data_mem_data_i = '0;
    resp_g = 1'b1;
    tag_g = 1'b1;
    stat_g = 1'b1;
    data_g = 1'b1;
    stall_on = 1'b0;
    lfsr_r = 32'haace;
    cycle_cnt = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    dirty_pend = 1'b0;
    data_pend = 1'b0;
    for (int s = 0; s < LCE_SETS; s++) begin
      for (int w = 0; w < LCE_ASSOC; w++) begin
        dirty_mem[s][w] = 1'b0;
        block_mem[s][w] = block_pattern(s, w);
      end
    end

    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    check_reset_sweep();
    check_set_clear(22'h01a5c8, 2'd1);
    check_sync();
    run_coherence_tests();
    stall_on = 1'b1;
    run_coherence_tests();

    total = errors + i_dut.i_assert.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, checks, errors, i_dut.i_assert.fail_cnt);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+dv
verilog/lce_pkg.sv
verilog/lce_init_sync.sv
verilog/lce_coherence_fsm.sv
verilog/lce_cmd_top.sv
dv/lce_cmd_assert.sv
dv/tb_lce_cmd.sv
